//--- src/mon_bus_pkg.sv
//==========================================================
// Register bus definitions
// Bus widths, bar select bits and the word maps of the
// statistics bar and the rule table bar
//==========================================================
`default_nettype none

package mon_bus_pkg;

	localparam int bus_data_width = 32;
	localparam int bus_addr_width = 32;

	// Bus2IP_CS bit per bar
	localparam int bar_stats = 1;
	localparam int bar_table = 0;

	// Bar 0, statistics
	localparam int reg_ctrl = 0;
	localparam int reg_pkt_cnt_base = 1;
	localparam int reg_byte_cnt_base = 5;
	localparam int reg_hit_cnt = 9;
	localparam int stats_num_words = 10;
	localparam int ctrl_rst_stats_bit = 0;
	localparam int ctrl_freeze_bit = 1;

	// Bar 1, rule table staging
	localparam int tbl_col_sip = 0;
	localparam int tbl_col_sip_mask = 1;
	localparam int tbl_col_dip = 2;
	localparam int tbl_col_dip_mask = 3;
	localparam int tbl_col_l4ports = 4;
	localparam int tbl_col_l4ports_mask = 5;
	localparam int tbl_col_proto = 6;
	localparam int tbl_col_proto_mask = 7;
	localparam int tbl_num_cols = 8;
	localparam int tbl_col_idx_width = 3;
	localparam int tbl_reg_row = 8;
	localparam int tbl_reg_cmd = 9;
	localparam int tbl_num_words = 10;

	// Command word values
	localparam int tbl_cmd_write = 1;
	localparam int tbl_cmd_read = 2;

endpackage

`default_nettype wire

//--- src/mon_pkt_pkg.sv
//==========================================================
// Packet descriptor and rule definitions
// Tuple field widths, port count, table depth and the
// packed rule layout shared by table and lookup
//==========================================================
`default_nettype none

package mon_pkt_pkg;

	localparam int ip_width = 32;
	localparam int proto_width = 8;
	localparam int l4_port_width = 16;
	localparam int tuple_width = 2 * l4_port_width + 2 * ip_width + proto_width;

	localparam int rule_depth = 16;
	localparam int rule_idx_width = 4;

	localparam int num_ports = 4;
	localparam int port_idx_width = 2;
	localparam int pkt_len_width = 16;
	localparam int cnt_width = 32;

	// Tuple order, MSB first: sport, dport, dip, sip, proto
	// A mask uses the same layout, one bit means compare
	typedef struct packed {
		logic [l4_port_width-1:0] sport;
		logic [l4_port_width-1:0] dport;
		logic [ip_width-1:0]      dip;
		logic [ip_width-1:0]      sip;
		logic [proto_width-1:0]   proto;
	} rule_t;

endpackage

`default_nettype wire

//--- src/bus_resp_mux.sv
//==========================================================
// Bus response merge
// Registers the two bars' acknowledges and errors and
// selects the read data of the bar that answered
//==========================================================
`default_nettype none

module bus_resp_mux import mon_bus_pkg::*; (
	input  wire                       Bus2IP_Clk,
	input  wire                       rst_n,
	input  wire [bus_data_width-1:0]  stats_data,
	input  wire                       stats_rdack,
	input  wire                       stats_wrack,
	input  wire                       stats_error,
	input  wire [bus_data_width-1:0]  table_data,
	input  wire                       table_rdack,
	input  wire                       table_wrack,
	input  wire                       table_error,
	output logic [bus_data_width-1:0] ip2bus_data,
	output logic                      ip2bus_rdack,
	output logic                      ip2bus_wrack,
	output logic                      ip2bus_error
);

	always_ff @(posedge Bus2IP_Clk) begin
		if (!rst_n) begin
			ip2bus_rdack <= 1'b0;
			ip2bus_wrack <= 1'b0;
			ip2bus_error <= 1'b0;
		end else begin
			ip2bus_rdack <= stats_rdack | table_rdack;
			ip2bus_wrack <= stats_wrack | table_wrack;
			ip2bus_error <= stats_error | table_error;
		end
	end

	always_ff @(posedge Bus2IP_Clk) begin
		case ({table_rdack, stats_rdack})
			2'b01:   ip2bus_data <= stats_data;
			2'b10:   ip2bus_data <= table_data;
			default: ip2bus_data <= '0;
		endcase
	end

	// Only one bar is selected at a time, so answers never overlap
	a_one_bar: assert property (@(posedge Bus2IP_Clk) disable iff (!rst_n)
		!((stats_rdack || stats_wrack) && (table_rdack || table_wrack)));

endmodule

`default_nettype wire

//--- src/stats_regs.sv
//==========================================================
// Statistics register bank, bar 0
// Control bits for clear and freeze, read access to the
// per-port counters and the hit counter
//==========================================================
`default_nettype none

module stats_regs import mon_bus_pkg::*, mon_pkt_pkg::*; (
	input  wire                       Bus2IP_Clk,
	input  wire                       rst_n,
	input  wire [bus_addr_width-1:0]  Bus2IP_Addr,
	input  wire                       bar_cs,
	input  wire                       bus2ip_rnw,
	input  wire [bus_data_width-1:0]  bus2ip_data,
	output logic [bus_data_width-1:0] rd_data,
	output logic                      rdack,
	output logic                      wrack,
	output logic                      error,
	output logic                      rst_stats,
	output logic                      stats_freeze,
	input  wire [cnt_width-1:0]       pkt_cnt [num_ports],
	input  wire [cnt_width-1:0]       byte_cnt [num_ports],
	input  wire [cnt_width-1:0]       hit_cnt
);

	logic                      cs_q;
	logic                      start;
	logic                      bad_addr;
	logic [bus_addr_width-3:0] word;
	logic [bus_data_width-1:0] rd_word;

	assign start = bar_cs && !cs_q;
	assign word = Bus2IP_Addr[bus_addr_width-1:2];
	assign bad_addr = word >= stats_num_words;

	// Read decode, anything unmapped reads zero
	always_comb begin
		rd_word = '0;
		if (word == reg_ctrl) begin
			rd_word[ctrl_rst_stats_bit] = rst_stats;
			rd_word[ctrl_freeze_bit] = stats_freeze;
		end else if (word >= reg_pkt_cnt_base && word < reg_byte_cnt_base) begin
			rd_word = pkt_cnt[port_idx_width'(word - reg_pkt_cnt_base)];
		end else if (word >= reg_byte_cnt_base && word < reg_hit_cnt) begin
			rd_word = byte_cnt[port_idx_width'(word - reg_byte_cnt_base)];
		end else if (word == reg_hit_cnt) begin
			rd_word = hit_cnt;
		end
	end

	always_ff @(posedge Bus2IP_Clk) begin
		if (!rst_n) begin
			cs_q <= 1'b0;
			rdack <= 1'b0;
			wrack <= 1'b0;
			error <= 1'b0;
			rst_stats <= 1'b0;
			stats_freeze <= 1'b0;
		end else begin
			cs_q <= bar_cs;
			rdack <= start && bus2ip_rnw;
			wrack <= start && !bus2ip_rnw;
			error <= start && bad_addr;
			// Only the control word is writable
			if (start && !bus2ip_rnw && word == reg_ctrl) begin
				rst_stats <= bus2ip_data[ctrl_rst_stats_bit];
				stats_freeze <= bus2ip_data[ctrl_freeze_bit];
			end
		end
	end

	always_ff @(posedge Bus2IP_Clk) begin
		if (start)
			rd_data <= rd_word;
	end

	// Master holds the access steady while the select is high
	a_req_stable: assert property (@(posedge Bus2IP_Clk) disable iff (!rst_n)
		bar_cs && cs_q |-> $stable(Bus2IP_Addr) && $stable(bus2ip_rnw));

endmodule

`default_nettype wire

//--- src/port_stats.sv
//==========================================================
// Port statistics
// Packet and byte counters per input port plus a total
// rule hit counter, with freeze and clear control
//==========================================================
`default_nettype none

module port_stats import mon_pkt_pkg::*; (
	input  wire                       Bus2IP_Clk,
	input  wire                       rst_n,
	input  wire                       rst_stats,
	input  wire                       stats_freeze,
	input  wire                       pkt_valid,
	input  wire [port_idx_width-1:0]  pkt_port,
	input  wire [pkt_len_width-1:0]   pkt_len,
	input  wire                       lookup_valid,
	input  wire                       lookup_hit,
	output logic [cnt_width-1:0]      pkt_cnt [num_ports],
	output logic [cnt_width-1:0]      byte_cnt [num_ports],
	output logic [cnt_width-1:0]      hit_cnt
);

	// Clear beats freeze, counters wrap on overflow
	always_ff @(posedge Bus2IP_Clk) begin
		if (!rst_n || rst_stats) begin
			for (int i = 0; i < num_ports; i++) begin
				pkt_cnt[i] <= '0;
				byte_cnt[i] <= '0;
			end
			hit_cnt <= '0;
		end else if (!stats_freeze) begin
			if (pkt_valid) begin
				pkt_cnt[pkt_port] <= pkt_cnt[pkt_port] + 1'b1;
				byte_cnt[pkt_port] <= byte_cnt[pkt_port] + cnt_width'(pkt_len);
			end
			if (lookup_valid && lookup_hit)
				hit_cnt <= hit_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- src/rule_table_regs.sv
//==========================================================
// Rule table register bank, bar 1
// Eight staging columns and a row register, with commands
// that move one row between staging and the table
//==========================================================
`default_nettype none

module rule_table_regs import mon_bus_pkg::*, mon_pkt_pkg::*; (
	input  wire                       Bus2IP_Clk,
	input  wire                       rst_n,
	input  wire [bus_addr_width-1:0]  Bus2IP_Addr,
	input  wire                       bar_cs,
	input  wire                       bus2ip_rnw,
	input  wire [bus_data_width-1:0]  bus2ip_data,
	output logic [bus_data_width-1:0] rd_data,
	output logic                      rdack,
	output logic                      wrack,
	output logic                      error,
	output logic [rule_idx_width-1:0] tbl_row,
	output logic                      tbl_wr_req,
	output rule_t                     tbl_wr_rule,
	output rule_t                     tbl_wr_mask,
	output logic                      tbl_rd_req,
	input  wire                       tbl_ack,
	input  rule_t                     tbl_rd_rule,
	input  rule_t                     tbl_rd_mask
);

	logic                         cs_q;
	logic                         start;
	logic                         wr_start;
	logic                         cmd_wr;
	logic                         rd_pend;
	logic [bus_addr_width-3:0]    word;
	logic [tbl_col_idx_width-1:0] col_idx;
	logic [bus_data_width-1:0]    rd_word;
	logic [bus_data_width-1:0]    col [tbl_num_cols];

	assign start = bar_cs && !cs_q;
	assign wr_start = start && !bus2ip_rnw;
	assign word = Bus2IP_Addr[bus_addr_width-1:2];
	assign col_idx = word[tbl_col_idx_width-1:0];

	// Requests go out in the select edge cycle
	assign cmd_wr = wr_start && word == tbl_reg_cmd;
	assign tbl_wr_req = cmd_wr && bus2ip_data == tbl_cmd_write;
	assign tbl_rd_req = cmd_wr && bus2ip_data == tbl_cmd_read;

	// Rule and mask columns interleave, so the mask is the next word
	assign tbl_wr_rule = {col[tbl_col_l4ports], col[tbl_col_dip], col[tbl_col_sip],
		col[tbl_col_proto][proto_width-1:0]};
	assign tbl_wr_mask = {col[tbl_col_l4ports_mask], col[tbl_col_dip_mask],
		col[tbl_col_sip_mask], col[tbl_col_proto_mask][proto_width-1:0]};

	always_comb begin
		rd_word = '0;
		if (word < tbl_num_cols)
			rd_word = col[col_idx];
		else if (word == tbl_reg_row)
			rd_word = bus_data_width'(tbl_row);
	end

	always_ff @(posedge Bus2IP_Clk) begin
		if (!rst_n) begin
			cs_q <= 1'b0;
			rdack <= 1'b0;
			wrack <= 1'b0;
			error <= 1'b0;
			rd_pend <= 1'b0;
			tbl_row <= '0;
			for (int i = 0; i < tbl_num_cols; i++)
				col[i] <= '0;
		end else begin
			cs_q <= bar_cs;
			rdack <= start && bus2ip_rnw;
			// Commands answer once the table has
			wrack <= (wr_start && !tbl_wr_req && !tbl_rd_req) || tbl_ack;
			error <= start && word >= tbl_num_words;
			if (tbl_rd_req)
				rd_pend <= 1'b1;
			else if (tbl_ack)
				rd_pend <= 1'b0;

			if (wr_start && word == tbl_reg_row)
				tbl_row <= bus2ip_data[rule_idx_width-1:0];

			if (wr_start && word < tbl_num_cols) begin
				// Proto columns are only 8 bits wide
				if (word == tbl_col_proto || word == tbl_col_proto_mask)
					col[col_idx] <= bus_data_width'(bus2ip_data[proto_width-1:0]);
				else
					col[col_idx] <= bus2ip_data;
			end else if (tbl_ack && rd_pend) begin
				col[tbl_col_sip] <= tbl_rd_rule.sip;
				col[tbl_col_sip_mask] <= tbl_rd_mask.sip;
				col[tbl_col_dip] <= tbl_rd_rule.dip;
				col[tbl_col_dip_mask] <= tbl_rd_mask.dip;
				col[tbl_col_l4ports] <= {tbl_rd_rule.sport, tbl_rd_rule.dport};
				col[tbl_col_l4ports_mask] <= {tbl_rd_mask.sport, tbl_rd_mask.dport};
				col[tbl_col_proto] <= bus_data_width'(tbl_rd_rule.proto);
				col[tbl_col_proto_mask] <= bus_data_width'(tbl_rd_mask.proto);
			end
		end
	end

	always_ff @(posedge Bus2IP_Clk) begin
		if (start)
			rd_data <= rd_word;
	end

endmodule

`default_nettype wire

//--- src/rule_tcam.sv
//==========================================================
// Rule TCAM
// Sixteen masked 5-tuple rules with a bus read/write port
// and a two-cycle lookup, lowest matching row wins
//==========================================================
`default_nettype none

module rule_tcam import mon_pkt_pkg::*; (
	input  wire                       Bus2IP_Clk,
	input  wire                       rst_n,
	input  wire [rule_idx_width-1:0]  tbl_row,
	input  wire                       tbl_wr_req,
	input  rule_t                     tbl_wr_rule,
	input  rule_t                     tbl_wr_mask,
	input  wire                       tbl_rd_req,
	output logic                      tbl_ack,
	output rule_t                     tbl_rd_rule,
	output rule_t                     tbl_rd_mask,
	input  wire                       pkt_valid,
	input  wire [port_idx_width-1:0]  pkt_port,
	input  wire [ip_width-1:0]        pkt_sip,
	input  wire [ip_width-1:0]        pkt_dip,
	input  wire [proto_width-1:0]     pkt_proto,
	input  wire [l4_port_width-1:0]   pkt_sport,
	input  wire [l4_port_width-1:0]   pkt_dport,
	output logic                      lookup_valid,
	output logic                      lookup_hit,
	output logic [rule_idx_width-1:0] lookup_rule,
	output logic [port_idx_width-1:0] lookup_port
);

	rule_t                     rule_mem [rule_depth];
	rule_t                     mask_mem [rule_depth];
	logic [rule_depth-1:0]     row_valid;
	logic [tuple_width-1:0]    pkt_tuple;
	rule_t                     pkt_q;
	logic [port_idx_width-1:0] port_q;
	logic                      valid_q;
	logic [rule_depth-1:0]     match;
	logic [rule_depth-1:0]     hit_q;

	assign pkt_tuple = {pkt_sport, pkt_dport, pkt_dip, pkt_sip, pkt_proto};

	// Table port, answered one cycle after the request
	always_ff @(posedge Bus2IP_Clk) begin
		if (tbl_wr_req) begin
			rule_mem[tbl_row] <= tbl_wr_rule;
			mask_mem[tbl_row] <= tbl_wr_mask;
		end
		if (tbl_rd_req) begin
			tbl_rd_rule <= rule_mem[tbl_row];
			tbl_rd_mask <= mask_mem[tbl_row];
		end
	end

	always_ff @(posedge Bus2IP_Clk) begin
		if (!rst_n) begin
			row_valid <= '0;
			tbl_ack <= 1'b0;
			valid_q <= 1'b0;
			lookup_valid <= 1'b0;
		end else begin
			if (tbl_wr_req)
				row_valid[tbl_row] <= 1'b1;
			tbl_ack <= tbl_wr_req || tbl_rd_req;
			valid_q <= pkt_valid;
			lookup_valid <= valid_q;
		end
	end

	// Captured tuple meets the table of the following cycle
	always_comb begin
		for (int i = 0; i < rule_depth; i++)
			match[i] = row_valid[i] && (((pkt_q ^ rule_mem[i]) & mask_mem[i]) == '0);
	end

	always_ff @(posedge Bus2IP_Clk) begin
		pkt_q <= pkt_tuple;
		port_q <= pkt_port;
		hit_q <= match;
		lookup_port <= port_q;
	end

	// Lowest set row wins
	always_comb begin
		lookup_rule = '0;
		for (int i = rule_depth - 1; i >= 0; i--) begin
			if (hit_q[i])
				lookup_rule = rule_idx_width'(i);
		end
	end

	assign lookup_hit = |hit_q;

	// Reported row matched and no lower row did
	a_lowest_row: assert property (@(posedge Bus2IP_Clk) disable iff (!rst_n)
		lookup_valid && lookup_hit |-> hit_q[lookup_rule] &&
			(hit_q & ((rule_depth'(1) << lookup_rule) - rule_depth'(1))) == '0);

endmodule

`default_nettype wire

//--- src/mon_top.sv
//==========================================================
// Monitoring lookup top level
// Register bus with two bars, rule table, packet lookup
// and per-port statistics
//==========================================================
`default_nettype none

module mon_top import mon_bus_pkg::*, mon_pkt_pkg::*; (
	input  wire                       Bus2IP_Clk,
	input  wire                       rst_n,
	input  wire [bus_addr_width-1:0]  Bus2IP_Addr,
	input  wire [1:0]                 Bus2IP_CS,
	input  wire                       bus2ip_rnw,
	input  wire [bus_data_width-1:0]  bus2ip_data,
	output logic [bus_data_width-1:0] ip2bus_data,
	output logic                      ip2bus_rdack,
	output logic                      ip2bus_wrack,
	output logic                      ip2bus_error,
	input  wire                       pkt_valid,
	input  wire [port_idx_width-1:0]  pkt_port,
	input  wire [pkt_len_width-1:0]   pkt_len,
	input  wire [ip_width-1:0]        pkt_sip,
	input  wire [ip_width-1:0]        pkt_dip,
	input  wire [proto_width-1:0]     pkt_proto,
	input  wire [l4_port_width-1:0]   pkt_sport,
	input  wire [l4_port_width-1:0]   pkt_dport,
	output logic                      lookup_valid,
	output logic                      lookup_hit,
	output logic [rule_idx_width-1:0] lookup_rule,
	output logic [port_idx_width-1:0] lookup_port
);

	logic [bus_data_width-1:0] stats_data;
	logic                      stats_rdack;
	logic                      stats_wrack;
	logic                      stats_error;
	logic [bus_data_width-1:0] table_data;
	logic                      table_rdack;
	logic                      table_wrack;
	logic                      table_error;

	logic                      rst_stats;
	logic                      stats_freeze;
	logic [cnt_width-1:0]      pkt_cnt [num_ports];
	logic [cnt_width-1:0]      byte_cnt [num_ports];
	logic [cnt_width-1:0]      hit_cnt;

	logic [rule_idx_width-1:0] tbl_row;
	logic                      tbl_wr_req;
	logic                      tbl_rd_req;
	logic                      tbl_ack;
	rule_t                     tbl_wr_rule;
	rule_t                     tbl_wr_mask;
	rule_t                     tbl_rd_rule;
	rule_t                     tbl_rd_mask;

	bus_resp_mux resp_mux_i (
		.Bus2IP_Clk   (Bus2IP_Clk),
		.rst_n        (rst_n),
		.stats_data   (stats_data),
		.stats_rdack  (stats_rdack),
		.stats_wrack  (stats_wrack),
		.stats_error  (stats_error),
		.table_data   (table_data),
		.table_rdack  (table_rdack),
		.table_wrack  (table_wrack),
		.table_error  (table_error),
		.ip2bus_data  (ip2bus_data),
		.ip2bus_rdack (ip2bus_rdack),
		.ip2bus_wrack (ip2bus_wrack),
		.ip2bus_error (ip2bus_error)
	);

	stats_regs stats_regs_i (
		.Bus2IP_Clk   (Bus2IP_Clk),
		.rst_n        (rst_n),
		.Bus2IP_Addr  (Bus2IP_Addr),
		.bar_cs       (Bus2IP_CS[bar_stats]),
		.bus2ip_rnw   (bus2ip_rnw),
		.bus2ip_data  (bus2ip_data),
		.rd_data      (stats_data),
		.rdack        (stats_rdack),
		.wrack        (stats_wrack),
		.error        (stats_error),
		.rst_stats    (rst_stats),
		.stats_freeze (stats_freeze),
		.pkt_cnt      (pkt_cnt),
		.byte_cnt     (byte_cnt),
		.hit_cnt      (hit_cnt)
	);

	port_stats port_stats_i (
		.Bus2IP_Clk   (Bus2IP_Clk),
		.rst_n        (rst_n),
		.rst_stats    (rst_stats),
		.stats_freeze (stats_freeze),
		.pkt_valid    (pkt_valid),
		.pkt_port     (pkt_port),
		.pkt_len      (pkt_len),
		.lookup_valid (lookup_valid),
		.lookup_hit   (lookup_hit),
		.pkt_cnt      (pkt_cnt),
		.byte_cnt     (byte_cnt),
		.hit_cnt      (hit_cnt)
	);

	rule_table_regs table_regs_i (
		.Bus2IP_Clk  (Bus2IP_Clk),
		.rst_n       (rst_n),
		.Bus2IP_Addr (Bus2IP_Addr),
		.bar_cs      (Bus2IP_CS[bar_table]),
		.bus2ip_rnw  (bus2ip_rnw),
		.bus2ip_data (bus2ip_data),
		.rd_data     (table_data),
		.rdack       (table_rdack),
		.wrack       (table_wrack),
		.error       (table_error),
		.tbl_row     (tbl_row),
		.tbl_wr_req  (tbl_wr_req),
		.tbl_wr_rule (tbl_wr_rule),
		.tbl_wr_mask (tbl_wr_mask),
		.tbl_rd_req  (tbl_rd_req),
		.tbl_ack     (tbl_ack),
		.tbl_rd_rule (tbl_rd_rule),
		.tbl_rd_mask (tbl_rd_mask)
	);

	rule_tcam tcam_i (
		.Bus2IP_Clk   (Bus2IP_Clk),
		.rst_n        (rst_n),
		.tbl_row      (tbl_row),
		.tbl_wr_req   (tbl_wr_req),
		.tbl_wr_rule  (tbl_wr_rule),
		.tbl_wr_mask  (tbl_wr_mask),
		.tbl_rd_req   (tbl_rd_req),
		.tbl_ack      (tbl_ack),
		.tbl_rd_rule  (tbl_rd_rule),
		.tbl_rd_mask  (tbl_rd_mask),
		.pkt_valid    (pkt_valid),
		.pkt_port     (pkt_port),
		.pkt_sip      (pkt_sip),
		.pkt_dip      (pkt_dip),
		.pkt_proto    (pkt_proto),
		.pkt_sport    (pkt_sport),
		.pkt_dport    (pkt_dport),
		.lookup_valid (lookup_valid),
		.lookup_hit   (lookup_hit),
		.lookup_rule  (lookup_rule),
		.lookup_port  (lookup_port)
	);

endmodule

`default_nettype wire

//--- sim/tb_mon_top.sv
//==========================================================
// Testbench for the monitoring lookup block
// Replays bus accesses and packets from the golden file
// and checks read data, errors and lookup results
//==========================================================
`default_nettype none

module tb_mon_top import mon_bus_pkg::*, mon_pkt_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// One golden line, kind is W, R or P
	typedef struct packed {
		logic [7:0]       kind;
		logic [8:0][31:0] f;
	} item_t;

	typedef struct packed {
		logic                      hit;
		logic [rule_idx_width-1:0] rule;
		logic [port_idx_width-1:0] port;
		logic [31:0]               due;
	} expect_t;

	logic                      Bus2IP_Clk;
	logic                      rst_n;
	logic [bus_addr_width-1:0] Bus2IP_Addr;
	logic [1:0]                Bus2IP_CS;
	logic                      bus2ip_rnw;
	logic [bus_data_width-1:0] bus2ip_data;
	logic [bus_data_width-1:0] ip2bus_data;
	logic                      ip2bus_rdack;
	logic                      ip2bus_wrack;
	logic                      ip2bus_error;
	logic                      pkt_valid;
	logic [port_idx_width-1:0] pkt_port;
	logic [pkt_len_width-1:0]  pkt_len;
	logic [ip_width-1:0]       pkt_sip;
	logic [ip_width-1:0]       pkt_dip;
	logic [proto_width-1:0]    pkt_proto;
	logic [l4_port_width-1:0]  pkt_sport;
	logic [l4_port_width-1:0]  pkt_dport;
	logic                      lookup_valid;
	logic                      lookup_hit;
	logic [rule_idx_width-1:0] lookup_rule;
	logic [port_idx_width-1:0] lookup_port;

	item_t       items [$];
	expect_t     exp_q [$];
	int          num_items = 0;
	logic [31:0] cyc = '0;

	mon_top dut_i (
		.Bus2IP_Clk   (Bus2IP_Clk),
		.rst_n        (rst_n),
		.Bus2IP_Addr  (Bus2IP_Addr),
		.Bus2IP_CS    (Bus2IP_CS),
		.bus2ip_rnw   (bus2ip_rnw),
		.bus2ip_data  (bus2ip_data),
		.ip2bus_data  (ip2bus_data),
		.ip2bus_rdack (ip2bus_rdack),
		.ip2bus_wrack (ip2bus_wrack),
		.ip2bus_error (ip2bus_error),
		.pkt_valid    (pkt_valid),
		.pkt_port     (pkt_port),
		.pkt_len      (pkt_len),
		.pkt_sip      (pkt_sip),
		.pkt_dip      (pkt_dip),
		.pkt_proto    (pkt_proto),
		.pkt_sport    (pkt_sport),
		.pkt_dport    (pkt_dport),
		.lookup_valid (lookup_valid),
		.lookup_hit   (lookup_hit),
		.lookup_rule  (lookup_rule),
		.lookup_port  (lookup_port)
	);

	initial begin
		Bus2IP_Clk = 1'b0;
		forever #4 Bus2IP_Clk = ~Bus2IP_Clk;
	end

	always @(posedge Bus2IP_Clk)
		cyc <= cyc + 1;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		assert (got === exp) else begin
			$display("** Error: %s expected %h got %h", name, exp, got);
			$display("STATUS: FAIL");
			$fatal(1);
		end
	endtask

	// Line types are told apart by their first character
	task automatic load_golden();
		int          fd;
		int          c;
		int          n;
		logic [31:0] v [9];
		item_t       it;
		fd = $fopen("sim/mon_golden.txt", "r");
		if (fd == 0)
			abort_run("Cannot open the golden file sim/mon_golden.txt");
		c = $fgetc(fd);
		while (c != -1) begin
			if (c == "#") begin
				while (c != "\n" && c != -1)
					c = $fgetc(fd);
			end else if (c == "W" || c == "R" || c == "P") begin
				for (int i = 0; i < 9; i++)
					v[i] = '0;
				if (c == "P") begin
					n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", v[0], v[1], v[2],
						v[3], v[4], v[5], v[6], v[7], v[8]);
					if (n != 9)
						abort_run("Malformed packet line in the golden file");
				end else begin
					n = $fscanf(fd, "%h %h %h %h", v[0], v[1], v[2], v[3]);
					if (n != 4)
						abort_run("Malformed bus line in the golden file");
				end
				it.kind = c[7:0];
				for (int i = 0; i < 9; i++)
					it.f[i] = v[i];
				items.push_back(it);
			end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
				abort_run("Unknown line type in the golden file");
			end
			c = $fgetc(fd);
		end
		$fclose(fd);
		num_items = items.size();
	endtask

	// Lets lookups and the hit counter settle
	task automatic wait_lookups_done();
		while (exp_q.size() > 0)
			@(negedge Bus2IP_Clk);
		repeat (2) @(negedge Bus2IP_Clk);
	endtask

	task automatic bus_access(input logic [31:0] bar, input logic [31:0] word,
		input logic [31:0] data, input logic rnw, input logic [31:0] exp_data,
		input logic [31:0] exp_err);
		logic [1:0] cs;
		cs = '0;
		cs[bar == 0 ? bar_stats : bar_table] = 1'b1;
		pkt_valid = 1'b0;
		wait_lookups_done();
		Bus2IP_Addr = word << 2;
		bus2ip_rnw = rnw;
		bus2ip_data = data;
		Bus2IP_CS = cs;
		do
			@(negedge Bus2IP_Clk);
		while (!(ip2bus_rdack || ip2bus_wrack));
		if (rnw) begin
			assert (ip2bus_rdack) else abort_run("Bus read answered with a write acknowledge");
			check_value("ip2bus_data", exp_data, ip2bus_data);
		end else begin
			assert (ip2bus_wrack) else abort_run("Bus write answered with a read acknowledge");
		end
		check_value("ip2bus_error", exp_err, ip2bus_error);
		Bus2IP_CS = '0;
		@(negedge Bus2IP_Clk);
	endtask

	task automatic send_packet(input item_t it);
		expect_t e;
		pkt_valid = 1'b1;
		pkt_port = it.f[0][port_idx_width-1:0];
		pkt_len = it.f[1][pkt_len_width-1:0];
		pkt_sip = it.f[2];
		pkt_dip = it.f[3];
		pkt_proto = it.f[4][proto_width-1:0];
		pkt_sport = it.f[5][l4_port_width-1:0];
		pkt_dport = it.f[6][l4_port_width-1:0];
		e.hit = it.f[7][0];
		e.rule = it.f[8][rule_idx_width-1:0];
		e.port = it.f[0][port_idx_width-1:0];
		e.due = cyc + 2;
		exp_q.push_back(e);
		@(negedge Bus2IP_Clk);
	endtask

	// Results must come in order, two cycles after each valid
	always @(negedge Bus2IP_Clk) begin : lookup_check
		expect_t e;
		if (rst_n && lookup_valid) begin
			assert (exp_q.size() > 0) else abort_run("Lookup result with no packet in flight");
			e = exp_q.pop_front();
			assert (e.due == cyc) else abort_run("Lookup result came at the wrong cycle");
			check_value("lookup_hit", e.hit, lookup_hit);
			if (e.hit)
				check_value("lookup_rule", e.rule, lookup_rule);
			check_value("lookup_port", e.port, lookup_port);
		end else if (exp_q.size() > 0) begin
			assert (exp_q[0].due > cyc) else abort_run("Lookup result missing for a packet");
		end
	end

	initial begin : watchdog
		wait (num_items > 0);
		repeat (20 * num_items + 8) @(posedge Bus2IP_Clk);
		abort_run("Run timed out before all golden lines were replayed");
	end

	initial begin : main
		rst_n = 1'b0;
		Bus2IP_Addr = '0;
		Bus2IP_CS = '0;
		bus2ip_rnw = 1'b1;
		bus2ip_data = '0;
		pkt_valid = 1'b0;
		pkt_port = '0;
		pkt_len = '0;
		pkt_sip = '0;
		pkt_dip = '0;
		pkt_proto = '0;
		pkt_sport = '0;
		pkt_dport = '0;
		load_golden();
		if (num_items == 0)
			abort_run("Golden file holds no lines to replay");
		repeat (8) @(negedge Bus2IP_Clk);
		rst_n = 1'b1;
		@(negedge Bus2IP_Clk);
		foreach (items[i]) begin
			if (items[i].kind == "P")
				send_packet(items[i]);
			else if (items[i].kind == "W")
				bus_access(items[i].f[0], items[i].f[1], items[i].f[2], 1'b0, '0,
					items[i].f[3]);
			else
				bus_access(items[i].f[0], items[i].f[1], '0, 1'b1, items[i].f[2],
					items[i].f[3]);
		end
		pkt_valid = 1'b0;
		wait_lookups_done();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/mon_golden.txt
# Golden vectors, all fields hex, bar 0 is statistics and bar 1 the rule table
# W bar word data exp_err | R bar word exp_data exp_err
# P port len sip dip proto sport dport exp_hit exp_rule
# Row 2, 10.0.0.1 to 192.168.0.0/16 TCP dport 80
W 1 0 0A000001 0
W 1 1 FFFFFFFF 0
W 1 2 C0A80000 0
W 1 3 FFFF0000 0
W 1 4 00000050 0
W 1 5 0000FFFF 0
W 1 6 12345606 0
W 1 7 ABCDEFFF 0
W 1 8 2 0
W 1 9 1 0
# Row 5, any TCP from 10.0.0.0/8
W 1 0 0A000000 0
W 1 1 FF000000 0
W 1 3 00000000 0
W 1 5 00000000 0
W 1 8 5 0
W 1 9 1 0
# Row 9, UDP to 8.8.8.8 dport 53
W 1 1 00000000 0
W 1 2 08080808 0
W 1 3 FFFFFFFF 0
W 1 4 00000035 0
W 1 5 0000FFFF 0
W 1 6 00000011 0
W 1 8 9 0
W 1 9 1 0
# Read the rows back through staging
W 1 8 2 0
W 1 9 2 0
R 1 0 0A000001 0
R 1 1 FFFFFFFF 0
R 1 2 C0A80000 0
R 1 3 FFFF0000 0
R 1 4 00000050 0
R 1 5 0000FFFF 0
R 1 6 00000006 0
R 1 7 000000FF 0
W 1 8 5 0
W 1 9 2 0
R 1 0 0A000000 0
R 1 1 FF000000 0
R 1 3 00000000 0
R 1 5 00000000 0
W 1 8 9 0
W 1 9 2 0
R 1 1 00000000 0
R 1 2 08080808 0
R 1 3 FFFFFFFF 0
R 1 4 00000035 0
R 1 6 00000011 0
R 1 8 00000009 0
# Back-to-back packets
P 0 0040 0A000001 C0A80101 06 1234 0050 1 2
P 1 0100 0A000001 C0A8FFFE 06 ABCD 0050 1 2
P 2 05DC 0A000002 C0A80101 06 1234 0050 1 5
P 3 0080 0B000001 08080808 11 1000 0035 1 9
P 0 0020 0B000001 08080808 06 1000 0035 0 0
P 1 0010 0A000001 C0A80101 11 1234 0050 0 0
# Counters
R 0 1 00000002 0
R 0 2 00000002 0
R 0 3 00000001 0
R 0 4 00000001 0
R 0 5 00000060 0
R 0 6 00000110 0
R 0 7 000005DC 0
R 0 8 00000080 0
R 0 9 00000004 0
# Freeze
W 0 0 2 0
R 0 0 00000002 0
P 2 0100 0A000002 C0A80101 06 1234 0050 1 5
R 0 3 00000001 0
R 0 7 000005DC 0
R 0 9 00000004 0
# Clear, then resume counting
W 0 0 1 0
R 0 0 00000001 0
R 0 1 00000000 0
R 0 9 00000000 0
W 0 0 0 0
P 3 0040 0B000001 08080808 11 1000 0035 1 9
R 0 4 00000001 0
R 0 8 00000040 0
R 0 9 00000001 0
# Words past the end of each bar
R 0 A 00000000 1
W 0 F DEADBEEF 1
R 0 0 00000000 0
R 1 A 00000000 1
W 1 C 12345678 1
R 1 4 00000035 0

//--- list.f
src/mon_bus_pkg.sv
src/mon_pkt_pkg.sv
src/bus_resp_mux.sv
src/stats_regs.sv
src/port_stats.sv
src/rule_table_regs.sv
src/rule_tcam.sv
src/mon_top.sv
sim/tb_mon_top.sv

//--- Bender.yml
package:
  name: mon_lookup

sources:
  - src/mon_bus_pkg.sv
  - src/mon_pkt_pkg.sv
  - src/bus_resp_mux.sv
  - src/stats_regs.sv
  - src/port_stats.sv
  - src/rule_table_regs.sv
  - src/rule_tcam.sv
  - src/mon_top.sv
  - target: test
    files:
      - sim/tb_mon_top.sv
